//--- design/pet_bus_defines.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus widths, phi2 timing, ram size and apb register map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef PET_BUS_DEFINES_SVH
`define PET_BUS_DEFINES_SVH

// 6502 system bus
`define BUS_ADDR_W 16
`define BUS_DATA_W 8

// fast clock cycles per phi2 half period
`define PHI2_HALF 4

// ram occupies 0x0000 upward, everything else floats
`define RAM_WORDS 2048
`define OPEN_BUS 8'hFF

// apb side
`define APB_ADDR_W 8
`define APB_DATA_W 32
`define REG_CMD 8'h00
`define REG_CTRL 8'h04

`endif

//--- design/pet_bus_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus request type and apb command/status word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "pet_bus_defines.svh"

package pet_bus_pkg;

    // one manual bus cycle as handed to the sequencer
    typedef struct packed {
        logic                   we;
        logic [`BUS_ADDR_W-1:0] addr;
        logic [`BUS_DATA_W-1:0] wdata;
    } bus_req_t;

    // the CMD register word, read and written with different layouts
    typedef union packed {
        // write layout: [24] we, [23:8] addr, [7:0] data
        struct packed {
            logic [`APB_DATA_W-`BUS_ADDR_W-`BUS_DATA_W-2:0] spare;
            logic                                           we;
            logic [`BUS_ADDR_W-1:0]                         addr;
            logic [`BUS_DATA_W-1:0]                         data;
        } cmd_view;
        // read layout: [31] busy, [30] run, [7:0] last read byte
        struct packed {
            logic                                busy;
            logic                                run;
            logic [`APB_DATA_W-`BUS_DATA_W-3:0]  spare;
            logic [`BUS_DATA_W-1:0]              rdata;
        } status_view;
    } cmd_word_u;

endpackage

//--- design/bus_ifs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus_req_if and pet_bus_if
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "pet_bus_defines.svh"

// manual request path, apb port to sequencer
interface bus_req_if;
    import pet_bus_pkg::*;

    // valid holds with req until accept pulses
    logic                   valid;
    bus_req_t               req;
    logic                   accept;
    // done pulses at the end of the bus cycle, rdata valid alongside
    logic                   done;
    logic [`BUS_DATA_W-1:0] rdata;
    // run mode hands the bus to the cpu ports
    logic                   run;

    modport master (
        output valid,
        output req,
        output run,
        input  accept,
        input  done,
        input  rdata
    );

    modport slave (
        input  valid,
        input  req,
        input  run,
        output accept,
        output done,
        output rdata
    );
endinterface

// system bus, sequencer to memory
interface pet_bus_if;
    logic [`BUS_ADDR_W-1:0] addr;
    logic [`BUS_DATA_W-1:0] wdata;
    logic                   we_n;
    logic [`BUS_DATA_W-1:0] rdata;
    // end of cycle strobe, write commit point
    logic                   phi2_fall;

    modport master (
        output addr,
        output wdata,
        output we_n,
        output phi2_fall,
        input  rdata
    );

    modport slave (
        input  addr,
        input  wdata,
        input  we_n,
        input  phi2_fall,
        output rdata
    );
endinterface

//--- design/phi2_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// phi2 divider with edge strobes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "pet_bus_defines.svh"

module phi2_gen (
    input  logic cpu_clock_ne,
    input  logic rst_n_i,
    output logic phi2_o,
    output logic phi2_rise_o,
    output logic phi2_fall_o
);
    // wide enough for PHI2_HALF of 1
    localparam int CNT_W = $clog2(`PHI2_HALF + 1);

    logic [CNT_W-1:0] half_cnt;
    logic             phi2_q;

    // phi2 starts high and flips every PHI2_HALF cycles
    always_ff @(posedge cpu_clock_ne or negedge rst_n_i) begin
        if (!rst_n_i) begin
            half_cnt <= '0;
            phi2_o   <= 1'b1;
        end else if (half_cnt == CNT_W'(`PHI2_HALF - 1)) begin
            half_cnt <= '0;
            phi2_o   <= ~phi2_o;
        end else begin
            half_cnt <= half_cnt + 1'b1;
        end
    end

    // registered edge detect, strobes land one cycle after phi2 moves
    always_ff @(posedge cpu_clock_ne or negedge rst_n_i) begin
        if (!rst_n_i) begin
            phi2_q      <= 1'b1;
            phi2_rise_o <= 1'b0;
            phi2_fall_o <= 1'b0;
        end else begin
            phi2_q      <= phi2_o;
            phi2_rise_o <= phi2_o & ~phi2_q;
            phi2_fall_o <= ~phi2_o & phi2_q;
        end
    end
endmodule

//--- design/bus_apb_port.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// apb slave, cmd/status and ctrl registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "pet_bus_defines.svh"

module bus_apb_port (
    input  logic                   cpu_clock_ne,
    input  logic                   rst_n_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  logic [`APB_ADDR_W-1:0] paddr_i,
    input  logic [`APB_DATA_W-1:0] pwdata_i,
    output logic [`APB_DATA_W-1:0] prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o,
    bus_req_if.master              req
);
    import pet_bus_pkg::*;

    cmd_word_u              cmd;
    cmd_word_u              status;
    logic                   wr_cmd;
    logic                   wr_ctrl;
    logic                   cmd_ok;
    logic                   busy;
    logic                   run;
    logic [`BUS_DATA_W-1:0] last_rdata;

    // access phase decode
    assign wr_cmd  = psel_i && penable_i && pwrite_i && (paddr_i == `REG_CMD);
    assign wr_ctrl = psel_i && penable_i && pwrite_i && (paddr_i == `REG_CTRL);

    // one request at a time, and none while the cpu owns the bus
    assign cmd_ok    = !busy && !run;
    assign pslverr_o = wr_cmd && !cmd_ok;

    // zero wait states
    assign pready_o = 1'b1;

    assign cmd     = pwdata_i;
    assign req.run = run;

    always_ff @(posedge cpu_clock_ne or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy       <= 1'b0;
            run        <= 1'b0;
            req.valid  <= 1'b0;
            last_rdata <= '0;
        end else begin
            if (wr_cmd && cmd_ok) begin
                busy      <= 1'b1;
                req.valid <= 1'b1;
            end else if (req.accept) begin
                req.valid <= 1'b0;
            end
            // writes leave the last read byte alone
            if (req.done) begin
                busy <= 1'b0;
                if (!req.req.we) begin
                    last_rdata <= req.rdata;
                end
            end
            if (wr_ctrl) begin
                run <= pwdata_i[0];
            end
        end
    end

    // request payload, only sampled while valid
    always_ff @(posedge cpu_clock_ne) begin
        if (wr_cmd && cmd_ok) begin
            req.req.we    <= cmd.cmd_view.we;
            req.req.addr  <= cmd.cmd_view.addr;
            req.req.wdata <= cmd.cmd_view.data;
        end
    end

    // read mux
    always_comb begin
        status                   = '0;
        status.status_view.busy  = busy;
        status.status_view.run   = run;
        status.status_view.rdata = last_rdata;
        prdata_o                 = '0;
        if (paddr_i == `REG_CMD) begin
            prdata_o = status;
        end else if (paddr_i == `REG_CTRL) begin
            prdata_o = `APB_DATA_W'(run);
        end
    end
endmodule

//--- design/bus_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus cycle sequencer, manual or cpu source
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "pet_bus_defines.svh"

module bus_sequencer (
    input  logic                   cpu_clock_ne,
    input  logic                   rst_n_i,
    input  logic                   phi2_rise_i,
    input  logic                   phi2_fall_i,
    input  logic [`BUS_ADDR_W-1:0] cpu_addr_i,
    input  logic [`BUS_DATA_W-1:0] cpu_wdata_i,
    input  logic                   cpu_we_i,
    input  logic                   cpu_ready_i,
    output logic                   cpu_ready_o,
    output logic [`BUS_DATA_W-1:0] cpu_rdata_o,
    bus_req_if.slave               req,
    pet_bus_if.master              bus
);
    logic [`BUS_ADDR_W-1:0] nxt_addr;
    logic [`BUS_DATA_W-1:0] nxt_wdata;
    logic                   nxt_we;
    logic                   take_manual;
    logic                   cyc_manual;
    logic                   done_q;
    logic [`BUS_DATA_W-1:0] rdata_q;

    // a pending manual request only goes out with the cpu parked
    assign take_manual = req.valid && !req.run;
    assign req.accept  = phi2_fall_i && take_manual;

    // source select for the next bus cycle
    always_comb begin
        if (req.run) begin
            nxt_addr  = cpu_addr_i;
            nxt_wdata = cpu_wdata_i;
            nxt_we    = cpu_we_i;
        end else if (take_manual) begin
            nxt_addr  = req.req.addr;
            nxt_wdata = req.req.wdata;
            nxt_we    = req.req.we;
        end else begin
            // idle, keep the address and drop back to read
            nxt_addr  = bus.addr;
            nxt_wdata = bus.wdata;
            nxt_we    = 1'b0;
        end
    end

    // launch on the cycle after the fall strobe, mimics 65C02 hold time
    always_ff @(posedge cpu_clock_ne or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bus.addr   <= '0;
            bus.wdata  <= '0;
            bus.we_n   <= 1'b1;
            cyc_manual <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            // the launch edge also closes the previous cycle
            done_q <= phi2_fall_i && cyc_manual;
            if (phi2_fall_i) begin
                bus.addr   <= nxt_addr;
                bus.wdata  <= nxt_wdata;
                bus.we_n   <= ~nxt_we;
                cyc_manual <= take_manual;
            end
        end
    end

    // read data captured mid cycle, held until the next rise
    always_ff @(posedge cpu_clock_ne) begin
        if (phi2_rise_i) begin
            rdata_q <= bus.rdata;
        end
    end

    assign req.done      = done_q;
    assign req.rdata     = rdata_q;
    assign cpu_rdata_o   = rdata_q;
    assign bus.phi2_fall = phi2_fall_i;

    // cpu stalls unless run mode is on
    assign cpu_ready_o = cpu_ready_i && req.run;
endmodule

//--- design/bus_memory.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 2 KiB ram with open-bus decode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "pet_bus_defines.svh"

module bus_memory (
    input  logic     cpu_clock_ne,
    pet_bus_if.slave bus
);
    localparam int RAM_AW = $clog2(`RAM_WORDS);

    logic [`BUS_DATA_W-1:0] ram [`RAM_WORDS];
    logic [RAM_AW-1:0]      ram_idx;
    logic                   in_ram;
    logic                   in_ram_q;
    logic [`BUS_DATA_W-1:0] ram_q;

    // ram sits at address 0
    assign in_ram  = bus.addr < `BUS_ADDR_W'(`RAM_WORDS);
    assign ram_idx = bus.addr[RAM_AW-1:0];

    // write commits at the end of the cycle, before the address moves
    always_ff @(posedge cpu_clock_ne) begin
        if (bus.phi2_fall && !bus.we_n && in_ram) begin
            ram[ram_idx] <= bus.wdata;
        end
    end

    // synchronous read, settles long before the rise sample
    always_ff @(posedge cpu_clock_ne) begin
        ram_q    <= ram[ram_idx];
        in_ram_q <= in_ram;
    end

    // nothing drives the bus outside ram
    assign bus.rdata = in_ram_q ? ram_q : `OPEN_BUS;
endmodule

//--- design/pet_bus_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pet bus engine top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "pet_bus_defines.svh"

module pet_bus_top (
    input  logic                   cpu_clock_ne,
    input  logic                   rst_n_i,
    // host apb
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  logic [`APB_ADDR_W-1:0] paddr_i,
    input  logic [`APB_DATA_W-1:0] pwdata_i,
    output logic [`APB_DATA_W-1:0] prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o,
    // external cpu
    input  logic [`BUS_ADDR_W-1:0] cpu_addr_i,
    input  logic [`BUS_DATA_W-1:0] cpu_wdata_i,
    input  logic                   cpu_we_i,
    input  logic                   cpu_ready_i,
    output logic                   cpu_ready_o,
    output logic [`BUS_DATA_W-1:0] cpu_rdata_o,
    // system bus
    output logic                   phi2_o,
    output logic [`BUS_ADDR_W-1:0] bus_addr_o,
    output logic [`BUS_DATA_W-1:0] bus_wdata_o,
    output logic                   bus_we_n_o
);
    logic phi2_rise;
    logic phi2_fall;

    bus_req_if req_if ();
    pet_bus_if bus_if ();

    phi2_gen u_phi2 (
        .cpu_clock_ne (cpu_clock_ne),
        .rst_n_i      (rst_n_i),
        .phi2_o       (phi2_o),
        .phi2_rise_o  (phi2_rise),
        .phi2_fall_o  (phi2_fall)
    );

    bus_apb_port u_apb (
        .cpu_clock_ne (cpu_clock_ne),
        .rst_n_i      (rst_n_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .req          (req_if.master)
    );

    bus_sequencer u_seq (
        .cpu_clock_ne (cpu_clock_ne),
        .rst_n_i      (rst_n_i),
        .phi2_rise_i  (phi2_rise),
        .phi2_fall_i  (phi2_fall),
        .cpu_addr_i   (cpu_addr_i),
        .cpu_wdata_i  (cpu_wdata_i),
        .cpu_we_i     (cpu_we_i),
        .cpu_ready_i  (cpu_ready_i),
        .cpu_ready_o  (cpu_ready_o),
        .cpu_rdata_o  (cpu_rdata_o),
        .req          (req_if.slave),
        .bus          (bus_if.master)
    );

    bus_memory u_mem (
        .cpu_clock_ne (cpu_clock_ne),
        .bus          (bus_if.slave)
    );

    // bus pins straight off the sequencer registers
    assign bus_addr_o  = bus_if.addr;
    assign bus_wdata_o = bus_if.wdata;
    assign bus_we_n_o  = bus_if.we_n;
endmodule

//--- bench/bus_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus watcher, value compares and error counts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "pet_bus_defines.svh"

module bus_checker (
    input  logic                   cpu_clock_ne,
    input  logic                   rst_n_i,
    input  logic                   phi2_i,
    input  logic [`BUS_ADDR_W-1:0] bus_addr_i,
    input  logic [`BUS_DATA_W-1:0] bus_wdata_i,
    input  logic                   bus_we_n_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pready_i,
    input  logic [`APB_DATA_W-1:0] prdata_i,
    input  logic                   pslverr_i,
    input  logic                   cpu_ready_i,
    input  logic [`BUS_DATA_W-1:0] cpu_rdata_i,
    // compare request from the testbench is taken at the next rising edge
    input  logic                   chk_en_i,
    input  logic [2:0]             chk_sel_i,
    input  logic [`APB_DATA_W-1:0] chk_exp_i,
    output int                     value_errs_o,
    output int                     timing_errs_o,
    output int                     checks_o
);
    logic [`BUS_ADDR_W-1:0]             addr_q;
    logic                               we_n_q;
    // phi2 as seen on the three previous rising edges with [0] the newest
    logic [2:0]                         phi2_hist;
    // address and data of the most recent bus write
    logic [`BUS_ADDR_W+`BUS_DATA_W-1:0] last_wr;
    int                                 low_len;
    int                                 writes;
    logic [`APB_DATA_W-1:0]             got;
    string                              what;

    always @(posedge cpu_clock_ne) begin
        if (!rst_n_i) begin
            addr_q    = '0;
            we_n_q    = 1'b1;
            phi2_hist = 3'b111;
            last_wr   = '0;
            low_len   = 0;
            writes    = 0;
        end else begin
            // bus pins may only move two cycles after phi2 went low
            if ((bus_addr_i !== addr_q || bus_we_n_i !== we_n_q) &&
                !(!phi2_hist[1] && phi2_hist[2])) begin
                timing_errs_o++;
                $display("bus address or write enable changed at %0t away from the launch edge",
                         $time);
            end
            // each write holds the strobe low for one phi2 period
            if (!bus_we_n_i) begin
                if (we_n_q) begin
                    writes++;
                    low_len = 1;
                    last_wr = {bus_addr_i, bus_wdata_i};
                end else begin
                    low_len++;
                end
            end else if (!we_n_q && low_len != 2 * `PHI2_HALF) begin
                timing_errs_o++;
                $display("write enable was low for %0d cycles instead of one phi2 period, at %0t",
                         low_len, $time);
            end
            // zero wait states on every access phase
            if (psel_i && penable_i) begin
                checks_o++;
                if (pready_i !== 1'b1) begin
                    value_errs_o++;
                    $display("[FAIL] %0t: pready low in an apb access phase", $time);
                end
            end
            addr_q    = bus_addr_i;
            we_n_q    = bus_we_n_i;
            phi2_hist = {phi2_hist[1:0], phi2_i};
        end

        if (chk_en_i) begin
            case (chk_sel_i)
                3'd0: begin
                    got  = prdata_i;
                    what = "prdata";
                end
                3'd1: begin
                    got  = {31'd0, pslverr_i};
                    what = "pslverr";
                end
                3'd2: begin
                    got  = {24'd0, cpu_rdata_i};
                    what = "cpu_rdata";
                end
                3'd3: begin
                    got  = {31'd0, cpu_ready_i};
                    what = "cpu_ready";
                end
                3'd4: begin
                    got  = {31'd0, bus_we_n_i};
                    what = "bus_we_n";
                end
                3'd5: begin
                    got  = writes;
                    what = "bus write count";
                end
                default: begin
                    got  = {8'd0, last_wr};
                    what = "last bus write";
                end
            endcase
            checks_o++;
            if (got !== chk_exp_i) begin
                value_errs_o++;
                $display("[FAIL] %0t: %s expected %h, got %h", $time, what, chk_exp_i, got);
            end
        end
    end
endmodule

//--- bench/tb_pet_bus.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench top, trace replay, lfsr ram sweep
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "pet_bus_defines.svh"

module tb_pet_bus;
    // compare selectors shared with bus_checker
    localparam logic [2:0] SEL_PRDATA  = 3'd0;
    localparam logic [2:0] SEL_PSLVERR = 3'd1;
    localparam logic [2:0] SEL_RDATA   = 3'd2;
    localparam logic [2:0] SEL_READY   = 3'd3;
    localparam logic [2:0] SEL_WE_N    = 3'd4;
    localparam logic [2:0] SEL_WRITES  = 3'd5;
    localparam logic [2:0] SEL_LAST_WR = 3'd6;
    localparam int MAX_OPS  = 64;
    localparam int SWEEP_N  = 16;
    localparam int PHI2_CYC = 2 * `PHI2_HALF;

    logic                   cpu_clock_ne;
    logic                   rst_n;
    logic                   psel, penable, pwrite;
    logic [`APB_ADDR_W-1:0] paddr;
    logic [`APB_DATA_W-1:0] pwdata, prdata;
    logic                   pready, pslverr;
    logic [`BUS_ADDR_W-1:0] cpu_addr, bus_addr;
    logic [`BUS_DATA_W-1:0] cpu_wdata, cpu_rdata, bus_wdata;
    logic                   cpu_we, cpu_ready, cpu_ready_out;
    logic                   phi2, bus_we_n;
    logic                   chk_en;
    logic [2:0]             chk_sel;
    logic [31:0]            chk_exp;
    int                     value_errs, timing_errs, checks;
    int                     setup_errs, n_ops, cycles, cycle_limit;
    // each trace line holds op, address, data and expected value
    logic [31:0]            trace_words [4*MAX_OPS];
    logic [31:0]            lfsr;
    logic [`BUS_DATA_W-1:0] shadow [`RAM_WORDS];
    logic [10:0]            sweep_addr [SWEEP_N];

    pet_bus_top dut0 (
        .cpu_clock_ne (cpu_clock_ne), .rst_n_i     (rst_n),
        .psel_i       (psel),         .penable_i   (penable),
        .pwrite_i     (pwrite),       .paddr_i     (paddr),
        .pwdata_i     (pwdata),       .prdata_o    (prdata),
        .pready_o     (pready),       .pslverr_o   (pslverr),
        .cpu_addr_i   (cpu_addr),     .cpu_wdata_i (cpu_wdata),
        .cpu_we_i     (cpu_we),       .cpu_ready_i (cpu_ready),
        .cpu_ready_o  (cpu_ready_out), .cpu_rdata_o (cpu_rdata),
        .phi2_o       (phi2),         .bus_addr_o  (bus_addr),
        .bus_wdata_o  (bus_wdata),    .bus_we_n_o  (bus_we_n)
    );

    bus_checker u_chk (
        .cpu_clock_ne (cpu_clock_ne), .rst_n_i       (rst_n),
        .phi2_i       (phi2),         .bus_addr_i    (bus_addr),
        .bus_wdata_i  (bus_wdata),    .bus_we_n_i    (bus_we_n),
        .psel_i       (psel),         .penable_i     (penable),
        .pready_i     (pready),       .prdata_i      (prdata),
        .pslverr_i    (pslverr),      .cpu_ready_i   (cpu_ready_out),
        .cpu_rdata_i  (cpu_rdata),    .chk_en_i      (chk_en),
        .chk_sel_i    (chk_sel),      .chk_exp_i     (chk_exp),
        .value_errs_o (value_errs),   .timing_errs_o (timing_errs),
        .checks_o     (checks)
    );

    always #5 cpu_clock_ne = ~cpu_clock_ne;

    // run limit is sized once the trace is loaded
    always @(posedge cpu_clock_ne) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // galois form with taps 32 30 26 25
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check_now(input logic [2:0] sel, input logic [31:0] exp);
        @(negedge cpu_clock_ne);
        chk_en  = 1'b1;
        chk_sel = sel;
        chk_exp = exp;
        @(negedge cpu_clock_ne);
        chk_en = 1'b0;
    endtask

    // setup then access phase with rd holding prdata after the access edge
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                            input logic check, input logic [2:0] sel, input logic [31:0] exp,
                            output logic [31:0] rd);
        @(negedge cpu_clock_ne);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge cpu_clock_ne);
        penable = 1'b1;
        chk_en  = check;
        chk_sel = sel;
        chk_exp = exp;
        @(negedge cpu_clock_ne);
        rd      = prdata;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        chk_en  = 1'b0;
    endtask

    // poll status until the busy bit drops
    task automatic wait_idle();
        logic [31:0] rd;
        rd = 32'h8000_0000;
        while (rd[31]) begin
            apb_xfer(1'b0, `REG_CMD, '0, 1'b0, SEL_PRDATA, '0, rd);
        end
    endtask

    // returns on the falling clock right after a bus launch
    task automatic wait_launch();
        @(negedge phi2);
        repeat (2) @(posedge cpu_clock_ne);
        @(negedge cpu_clock_ne);
    endtask

    // one cpu bus cycle with write enable held for that cycle only
    task automatic cpu_cycle(input logic we, input logic [15:0] addr, input logic [7:0] data);
        wait_launch();
        cpu_addr  = addr;
        cpu_wdata = data;
        cpu_we    = we;
        wait_launch();
        cpu_we = 1'b0;
        wait_launch();
    endtask

    task automatic run_op(input logic [31:0] op, input logic [31:0] addr,
                          input logic [31:0] data, input logic [31:0] exp);
        logic [31:0] rd;
        case (op)
            1: apb_xfer(1'b1, addr[7:0], data, 1'b1, SEL_PSLVERR, exp, rd);
            2: apb_xfer(1'b0, addr[7:0], data, 1'b1, SEL_PRDATA, exp, rd);
            3: begin
                wait_idle();
                apb_xfer(1'b0, `REG_CMD, '0, 1'b1, SEL_PRDATA, exp, rd);
            end
            4: begin
                cpu_cycle(1'b1, addr[15:0], data[7:0]);
                check_now(SEL_LAST_WR, {8'd0, addr[15:0], data[7:0]});
            end
            5: begin
                cpu_cycle(1'b0, addr[15:0], 8'h00);
                check_now(SEL_RDATA, exp);
            end
            6: begin
                @(negedge cpu_clock_ne);
                cpu_ready = data[0];
                check_now(SEL_READY, exp);
            end
            7: check_now(SEL_WE_N, exp);
            8: check_now(SEL_WRITES, exp);
            default: begin
                setup_errs++;
                $display("unknown operation %0h in the trace", op);
            end
        endcase
    endtask

    initial begin
        logic [31:0] bits;
        logic [31:0] rd;
        cpu_clock_ne = 1'b0;
        rst_n        = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        cpu_addr     = '0;
        cpu_wdata    = '0;
        cpu_we       = 1'b0;
        cpu_ready    = 1'b0;
        chk_en       = 1'b0;
        chk_sel      = '0;
        chk_exp      = '0;
        setup_errs   = 0;
        cycles       = 0;
        lfsr         = 32'h2ca1_80d2;
        for (int i = 0; i < 4 * MAX_OPS; i++) begin
            trace_words[i] = '0;
        end
        $readmemh("bench/pet_bus_trace.txt", trace_words);
        n_ops = 0;
        while (n_ops < MAX_OPS && trace_words[4*n_ops] != 0) begin
            n_ops++;
        end
        if (n_ops == 0) begin
            setup_errs++;
            $display("the trace file held no operations");
        end
        // each trace line and each sweep access gets four phi2 periods
        cycle_limit = (n_ops + 2 * SWEEP_N) * 4 * PHI2_CYC + 200;

        repeat (10) @(negedge cpu_clock_ne);
        rst_n = 1'b1;

        for (int i = 0; i < n_ops; i++) begin
            run_op(trace_words[4*i], trace_words[4*i+1], trace_words[4*i+2],
                   trace_words[4*i+3]);
        end

        // manual writes to pseudo-random ram bytes and then a read back of each
        for (int i = 0; i < SWEEP_N; i++) begin
            take_bits(11, bits);
            sweep_addr[i] = bits[10:0];
            take_bits(8, bits);
            shadow[sweep_addr[i]] = bits[7:0];
            apb_xfer(1'b1, `REG_CMD, {7'd0, 1'b1, 5'd0, sweep_addr[i], bits[7:0]},
                     1'b1, SEL_PSLVERR, '0, rd);
            wait_idle();
            check_now(SEL_LAST_WR, {8'd0, 5'd0, sweep_addr[i], bits[7:0]});
        end
        for (int i = 0; i < SWEEP_N; i++) begin
            apb_xfer(1'b1, `REG_CMD, {8'd0, 5'd0, sweep_addr[i], 8'd0},
                     1'b1, SEL_PSLVERR, '0, rd);
            wait_idle();
            apb_xfer(1'b0, `REG_CMD, '0, 1'b1, SEL_PRDATA, {24'd0, shadow[sweep_addr[i]]}, rd);
        end

        repeat (4) @(negedge cpu_clock_ne);
        $display("errors: %0d value, %0d timing, %0d setup, after %0d value checks",
                 value_errs, timing_errs, setup_errs, checks);
        if (value_errs == 0 && timing_errs == 0 && setup_errs == 0 && checks > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end
endmodule

//--- bench/pet_bus_trace.txt
// op addr data expected, all hex; op 0 ends the trace
// 1 apb write (exp pslverr), 2 apb read, 3 poll cmd then read, 4 cpu write,
// 5 cpu read, 6 cpu ready in/out, 7 bus_we_n, 8 bus write count
7 0000 00000000 00000001 // write enable idle after reset
6 0000 00000001 00000000 // cpu held off with run clear
2 0000 00000000 00000000 // status idle
1 0000 01012A5C 00000000 // manual write 0x5c to 0x012a
3 0000 00000000 00000000
1 0000 00012A00 00000000 // manual read back
3 0000 00000000 0000005C
1 0000 00123400 00000000 // outside ram, open bus
3 0000 00000000 000000FF
1 0000 0107FF33 00000000 // write top of ram
1 0000 01000011 00000001 // cmd while busy is refused
3 0000 00000000 000000FF
8 0000 00000000 00000002
1 0000 0007FF00 00000000
3 0000 00000000 00000033
1 0004 00000001 00000000 // run mode on
2 0004 00000000 00000001
1 0000 01000077 00000001 // cmd while running is refused
2 0000 00000000 40000033
6 0000 00000001 00000001 // ready passes through
6 0000 00000000 00000000
4 0200 000000C3 00000000 // cpu writes
4 0201 0000003C 00000000
5 0200 00000000 000000C3
5 0201 00000000 0000003C
5 012A 00000000 0000005C // earlier manual write seen by the cpu
5 4000 00000000 000000FF
8 0000 00000000 00000004
1 0004 00000000 00000000 // run mode off
6 0000 00000001 00000000
1 0000 00020000 00000000 // manual read of a cpu write
3 0000 00000000 000000C3
0 0000 00000000 00000000

//--- project.f
+incdir+design
design/pet_bus_pkg.sv
design/bus_ifs.sv
design/phi2_gen.sv
design/bus_apb_port.sv
design/bus_sequencer.sv
design/bus_memory.sv
design/pet_bus_top.sv
bench/bus_checker.sv
bench/tb_pet_bus.sv

//--- run_sim.sh
#!/bin/sh
# verilator build and run; the result comes from the simulation log
mkdir -p build &&
verilator --binary --timing -Wno-fatal -f project.f --top-module tb_pet_bus \
    --Mdir build/obj -o tb_pet_bus &&
./build/obj/tb_pet_bus | tee build/sim.log &&
! grep -q "Checks failed" build/sim.log &&
grep -q "All checks passed" build/sim.log &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
